//--- compile.f
hdl/sec_mem_pkg.sv
hdl/sec_mem_bank.sv
hdl/resp_queue.sv
hdl/proc_resp_acc.sv
hdl/sec_mem_top.sv
verif/tb_clk_gen.sv
verif/tb_checker.sv
verif/tb_top.sv

//--- hdl/proc_resp_acc.sv
/*
 * response access control
 * masks data of words tagged above the processor's level
 */

`timescale 1ns/1ns

module proc_resp_acc (
	input  logic                      clk,

	// from the response queue head
	input  logic                      head_val,
	output logic                      head_rdy,
	input  sec_mem_pkg::tagged_resp_t head_msg,

	// current processor level
	input  sec_mem_pkg::sec_level_t   proc_sec_level,

	// to the processor
	output logic                      proc_resp_val,
	input  logic                      proc_resp_rdy,
	output sec_mem_pkg::mem_resp_t    proc_resp_msg
);

	logic allow;

	// word level at or below processor level may be seen
	assign allow = (head_msg.level <= proc_sec_level);

	// handshake is not touched by the check
	assign proc_resp_val = head_val;
	assign head_rdy      = proc_resp_rdy;

	always_comb begin
		// type and opaque always go through
		proc_resp_msg = head_msg.resp;
		// denied, drop data to zero
		if (!allow) begin
			proc_resp_msg.data = '0;
		end
	end

	// ====================
	// checks
	// ====================

	// no leak of protected data on any valid cycle
	a_denied_zero: assert property (@(posedge clk)
		(proc_resp_val && (head_msg.level > proc_sec_level)) |->
		(proc_resp_msg.data == '0));

endmodule

//--- hdl/resp_queue.sv
/*
 * 4-entry response FIFO between the bank and the access control
 */

`timescale 1ns/1ns

module resp_queue (
	input  logic                      clk,
	input  logic                      arst_n,

	// write side, from the bank
	input  logic                      push_val,
	input  sec_mem_pkg::tagged_resp_t push_msg,
	output logic [2:0]                count,

	// read side, head of the queue
	output logic                      head_val,
	input  logic                      head_rdy,
	output sec_mem_pkg::tagged_resp_t head_msg
);

	sec_mem_pkg::tagged_resp_t          entries [sec_mem_pkg::QUEUE_DEPTH];
	logic [sec_mem_pkg::PTR_NBITS-1:0]  wr_ptr;
	logic [sec_mem_pkg::PTR_NBITS-1:0]  rd_ptr;
	logic                               pop;

	// head is valid whenever something is stored
	assign head_val = (count != 3'd0);
	assign head_msg = entries[rd_ptr];
	assign pop      = head_val && head_rdy;

	// ====================
	// pointers and count
	// ====================

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= 3'd0;
		end else begin
			// pointers wrap naturally, depth is a power of two
			if (push_val) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push_val, pop})
				2'b10:   count <= count + 3'd1;
				2'b01:   count <= count - 3'd1;
				default: count <= count;
			endcase
		end
	end

	// entry storage
	always_ff @(posedge clk) begin
		if (push_val) begin
			entries[wr_ptr] <= push_msg;
		end
	end

	// ====================
	// checks
	// ====================

	// bank credit check must keep us from overflowing
	a_no_push_full: assert property (@(posedge clk) disable iff (!arst_n)
		push_val |-> (count < 3'(sec_mem_pkg::QUEUE_DEPTH)));

	// a popped entry lies between the pointers, or every slot is taken
	a_no_pop_empty: assert property (@(posedge clk) disable iff (!arst_n)
		pop |-> ((wr_ptr != rd_ptr) || (count == 3'(sec_mem_pkg::QUEUE_DEPTH))));

endmodule

//--- hdl/sec_mem_bank.sv
/*
 * tagged word memory bank
 * one-cycle pipelined access, accepts only when the response queue has room
 */

`timescale 1ns/1ns

module sec_mem_bank (
	input  logic                      clk,
	input  logic                      arst_n,

	// request from the processor
	input  logic                      req_val,
	output logic                      req_rdy,
	input  sec_mem_pkg::mem_req_t     req_msg,

	// level of the requesting processor
	input  sec_mem_pkg::sec_level_t   proc_sec_level,

	// response queue side
	input  logic [2:0]                queue_count,
	output logic                      push_val,
	output sec_mem_pkg::tagged_resp_t push_msg
);

	// data and security tag per word
	logic [sec_mem_pkg::DATA_NBITS-1:0] mem_data [sec_mem_pkg::MEM_WORDS];
	sec_mem_pkg::sec_level_t            mem_tag  [sec_mem_pkg::MEM_WORDS];

	logic [sec_mem_pkg::IDX_NBITS-1:0]  idx;
	logic                               req_fire;
	logic [3:0]                         reserved;

	// word index from the byte address
	assign idx = req_msg.addr[sec_mem_pkg::IDX_NBITS+1:2];

	// ====================
	// credit check
	// ====================

	// entries already queued plus the one in flight in push_val
	// a slot popped this cycle is not counted, which only costs a cycle
	assign reserved = {1'b0, queue_count} + {3'b000, push_val};
	assign req_rdy  = (reserved < 4'(sec_mem_pkg::QUEUE_DEPTH));
	assign req_fire = req_val && req_rdy;

	// ====================
	// storage
	// ====================

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < sec_mem_pkg::MEM_WORDS; i++) begin
				mem_data[i] <= '0;
				mem_tag[i]  <= '0;
			end
		end else if (req_fire && (req_msg.msg_type == sec_mem_pkg::MEM_WRITE)) begin
			// the writer's level becomes the word's tag, lower or higher
			mem_data[idx] <= req_msg.data;
			mem_tag[idx]  <= proc_sec_level;
		end
	end

	// ====================
	// response stage
	// ====================

	// one request in flight at most, its valid bit
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			push_val <= 1'b0;
		end else begin
			push_val <= req_fire;
		end
	end

	// payload, only meaningful while push_val is high
	always_ff @(posedge clk) begin
		if (req_fire) begin
			push_msg.resp.msg_type <= req_msg.msg_type;
			push_msg.resp.opaque   <= req_msg.opaque;
			if (req_msg.msg_type == sec_mem_pkg::MEM_WRITE) begin
				// write ack has no data, tag is the new one
				push_msg.resp.data <= '0;
				push_msg.level     <= proc_sec_level;
			end else begin
				push_msg.resp.data <= mem_data[idx];
				push_msg.level     <= mem_tag[idx];
			end
		end
	end

	// processor keeps the message fully defined while it asks
	a_req_known: assert property (@(posedge clk) disable iff (!arst_n)
		req_val |-> !$isunknown(req_msg));

endmodule

//--- hdl/sec_mem_pkg.sv
/*
 * security-tagged memory port shared definitions
 * message formats, request type and sizing constants
 */

package sec_mem_pkg;

	// ====================
	// sizing
	// ====================

	// opaque tag carried from request to response
	localparam int OPAQUE_NBITS = 8;
	localparam int ADDR_NBITS   = 32;
	localparam int DATA_NBITS   = 32;
	localparam int SEC_NBITS    = 2;

	// word memory, word index is addr[5:2]
	localparam int MEM_WORDS    = 16;
	localparam int IDX_NBITS    = $clog2(MEM_WORDS);

	// response buffering
	localparam int QUEUE_DEPTH  = 4;
	localparam int PTR_NBITS    = $clog2(QUEUE_DEPTH);
	localparam int CNT_NBITS    = $clog2(QUEUE_DEPTH + 1);

	// ====================
	// types
	// ====================

	// higher value is more privileged
	typedef logic [SEC_NBITS-1:0] sec_level_t;

	typedef enum logic {
		MEM_READ  = 1'b0,
		MEM_WRITE = 1'b1
	} mem_type_e;

	// request, 73 bits
	typedef struct packed {
		mem_type_e               msg_type;
		logic [OPAQUE_NBITS-1:0] opaque;
		logic [ADDR_NBITS-1:0]   addr;
		logic [DATA_NBITS-1:0]   data;
	} mem_req_t;

	// response, 41 bits
	typedef struct packed {
		mem_type_e               msg_type;
		logic [OPAQUE_NBITS-1:0] opaque;
		logic [DATA_NBITS-1:0]   data;
	} mem_resp_t;

	// response plus the level of the stored word, internal only
	typedef struct packed {
		mem_resp_t  resp;
		sec_level_t level;
	} tagged_resp_t;

endpackage

//--- hdl/sec_mem_top.sv
/*
 * security-tagged memory port top
 * bank, response queue and response access control
 */

`timescale 1ns/1ns

module sec_mem_top (
	input  logic                    clk,
	input  logic                    arst_n,

	// processor request port
	input  logic                    req_val,
	output logic                    req_rdy,
	input  sec_mem_pkg::mem_req_t   req_msg,

	// processor level, stable while responses are outstanding
	input  sec_mem_pkg::sec_level_t proc_sec_level,

	// processor response port
	output logic                    proc_resp_val,
	input  logic                    proc_resp_rdy,
	output sec_mem_pkg::mem_resp_t  proc_resp_msg
);

	// bank to queue
	logic                      push_val;
	sec_mem_pkg::tagged_resp_t push_msg;
	logic [2:0]                queue_count;

	// queue head to access control
	logic                      head_val;
	logic                      head_rdy;
	sec_mem_pkg::tagged_resp_t head_msg;

	// ====================
	// datapath
	// ====================

	sec_mem_bank bank_i (
		.clk            (clk),
		.arst_n         (arst_n),
		.req_val        (req_val),
		.req_rdy        (req_rdy),
		.req_msg        (req_msg),
		.proc_sec_level (proc_sec_level),
		.queue_count    (queue_count),
		.push_val       (push_val),
		.push_msg       (push_msg)
	);

	// absorbs processor back-pressure
	resp_queue queue_i (
		.clk      (clk),
		.arst_n   (arst_n),
		.push_val (push_val),
		.push_msg (push_msg),
		.count    (queue_count),
		.head_val (head_val),
		.head_rdy (head_rdy),
		.head_msg (head_msg)
	);

	// zero-cycle check on the way out
	proc_resp_acc acc_i (
		.clk            (clk),
		.head_val       (head_val),
		.head_rdy       (head_rdy),
		.head_msg       (head_msg),
		.proc_sec_level (proc_sec_level),
		.proc_resp_val  (proc_resp_val),
		.proc_resp_rdy  (proc_resp_rdy),
		.proc_resp_msg  (proc_resp_msg)
	);

endmodule

//--- run.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module tb_top \
	--Mdir obj_dir \
	-o sim_tb \
	-f compile.f

./obj_dir/sim_tb | tee sim.log

if grep -q "TESTS FAILED" sim.log; then
	exit 1
fi
exit 0

//--- verif/tb_checker.sv
/*
 * response checker
 * queues the expected response at each request transfer, compares at each response
 * and holds req_rdy to the credit rule on the outstanding count
 */

`timescale 1ns/1ns

module tb_checker (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   req_val,
	input  logic                   req_rdy,
	input  sec_mem_pkg::mem_req_t  req_msg,
	input  logic [31:0]            exp_data,
	input  logic                   proc_resp_val,
	input  logic                   proc_resp_rdy,
	input  sec_mem_pkg::mem_resp_t proc_resp_msg,
	input  logic                   done,
	output int                     error_count,
	output int                     pending
);

	sec_mem_pkg::mem_resp_t expected [$];
	int                     errors    = 0;
	int                     checked   = 0;
	logic                   reported  = 1'b0;
	logic                   full_seen = 1'b0;

	assign error_count = errors;

	// one line per response, FAIL lines for each wrong field
	task automatic compare_resp(input sec_mem_pkg::mem_resp_t exp,
			input sec_mem_pkg::mem_resp_t got);
		logic ok;
		ok = 1'b1;
		if (got.msg_type != exp.msg_type) begin
			$display("FAIL test %0d proc_resp_msg.msg_type got %h expected %h",
				exp.opaque, got.msg_type, exp.msg_type);
			ok = 1'b0;
		end
		if (got.opaque != exp.opaque) begin
			$display("FAIL test %0d proc_resp_msg.opaque got %h expected %h",
				exp.opaque, got.opaque, exp.opaque);
			ok = 1'b0;
		end
		if (got.data != exp.data) begin
			$display("FAIL test %0d proc_resp_msg.data got %h expected %h",
				exp.opaque, got.data, exp.data);
			ok = 1'b0;
		end
		if (ok) begin
			$display("pass test %0d data %h", exp.opaque, got.data);
		end else begin
			errors++;
		end
		checked++;
	endtask

	// sample at the falling edge, all DUT ports are settled there
	always @(negedge clk) begin : watch
		sec_mem_pkg::mem_resp_t exp;
		logic                   exp_rdy;
		if (arst_n) begin
			// requests taken minus responses delivered, before this cycle's transfers
			exp_rdy = (expected.size() < sec_mem_pkg::QUEUE_DEPTH);
			if (req_rdy !== exp_rdy) begin
				$display("FAIL req_rdy got %h expected %h with %0d outstanding",
					req_rdy, exp_rdy, expected.size());
				errors++;
			end
			if (!req_rdy) begin
				full_seen = 1'b1;
			end
			// a response never belongs to a request of the same cycle
			if (proc_resp_val && proc_resp_rdy) begin
				if (expected.size() == 0) begin
					$display("error: response with opaque %h arrived with nothing outstanding",
						proc_resp_msg.opaque);
					errors++;
				end else begin
					exp = expected.pop_front();
					compare_resp(exp, proc_resp_msg);
				end
			end
			// type and opaque come back as sent
			if (req_val && req_rdy) begin
				expected.push_back('{req_msg.msg_type, req_msg.opaque, exp_data});
			end
			pending = expected.size();
		end
		if (done && !reported) begin
			reported = 1'b1;
			if (expected.size() != 0) begin
				$display("error: %0d responses never arrived", expected.size());
				errors += expected.size();
			end
			if (!full_seen) begin
				$display("error: req_rdy never dropped, the queue was never filled");
				errors++;
			end
			$display("summary: %0d responses checked, %0d errors", checked, errors);
		end
	end

endmodule

//--- verif/tb_clk_gen.sv
/*
 * testbench clock and reset
 * 40 ns clock, reset held low for the first 3 rising edges
 */

`timescale 1ns/1ns

module tb_clk_gen (
	output logic clk,
	output logic arst_n
);

	localparam int HALF_PERIOD_NS = 20;

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD_NS clk = ~clk;
	end

	// release just after the third edge, away from the clock
	initial begin
		arst_n = 1'b0;
		repeat (3) @(posedge clk);
		#2 arst_n = 1'b1;
	end

endmodule

//--- verif/tb_top.sv
/*
 * testbench top for the security-tagged memory port
 * applies the stimulus table, random response back-pressure, timeout
 */

`timescale 1ns/1ns

module tb_top;

	typedef struct packed {
		sec_mem_pkg::mem_type_e                kind;
		logic [sec_mem_pkg::ADDR_NBITS-1:0]    addr;
		logic [sec_mem_pkg::DATA_NBITS-1:0]    data;
		sec_mem_pkg::sec_level_t               level;
		logic                                  bp;
		logic [sec_mem_pkg::DATA_NBITS-1:0]    exp_data;
	} stim_t;

	logic                   clk;
	logic                   arst_n;
	logic                   req_val       = 1'b0;
	logic                   req_rdy;
	sec_mem_pkg::mem_req_t  req_msg       = '0;
	sec_mem_pkg::sec_level_t proc_sec_level = '0;
	logic                   proc_resp_val;
	logic                   proc_resp_rdy = 1'b1;
	sec_mem_pkg::mem_resp_t proc_resp_msg;
	logic [31:0]            exp_data      = '0;
	logic                   done          = 1'b0;
	int                     error_count;
	int                     pending;

	stim_t                  stim [$];
	logic [31:0]            lfsr          = 32'hf1c6_3088;
	int                     cycle_count   = 0;
	int                     cycle_limit   = 0;

	tb_clk_gen clk_gen_i (
		.clk    (clk),
		.arst_n (arst_n)
	);

	sec_mem_top dut_i (
		.clk            (clk),
		.arst_n         (arst_n),
		.req_val        (req_val),
		.req_rdy        (req_rdy),
		.req_msg        (req_msg),
		.proc_sec_level (proc_sec_level),
		.proc_resp_val  (proc_resp_val),
		.proc_resp_rdy  (proc_resp_rdy),
		.proc_resp_msg  (proc_resp_msg)
	);

	tb_checker checker_i (
		.clk           (clk),
		.arst_n        (arst_n),
		.req_val       (req_val),
		.req_rdy       (req_rdy),
		.req_msg       (req_msg),
		.exp_data      (exp_data),
		.proc_resp_val (proc_resp_val),
		.proc_resp_rdy (proc_resp_rdy),
		.proc_resp_msg (proc_resp_msg),
		.done          (done),
		.error_count   (error_count),
		.pending       (pending)
	);

	// ====================
	// helpers
	// ====================

	// fibonacci lfsr, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic add_entry(input sec_mem_pkg::mem_type_e kind, input logic [31:0] addr,
			input logic [31:0] data, input sec_mem_pkg::sec_level_t level,
			input logic bp, input logic [31:0] exp);
		stim.push_back('{kind, addr, data, level, bp, exp});
	endtask

	// under back-pressure ready is high about one cycle in four
	task automatic set_resp_rdy(input logic bp);
		logic a;
		logic b;
		if (bp) begin
			lfsr = lfsr_next(lfsr);
			a    = lfsr[0];
			lfsr = lfsr_next(lfsr);
			b    = lfsr[0];
			proc_resp_rdy = a & b;
		end else begin
			proc_resp_rdy = 1'b1;
		end
	endtask

	// level may only change with nothing outstanding
	task automatic wait_drained();
		proc_resp_rdy = 1'b1;
		while (pending != 0) begin
			@(posedge clk);
			#2;
		end
	endtask

	task automatic build_table();
		// every word reads zero after reset, at any level
		for (int w = 0; w < sec_mem_pkg::MEM_WORDS; w++) begin
			add_entry(sec_mem_pkg::MEM_READ, 32'(4 * w), '0, 2'(w % 4), 1'b0, '0);
		end
		// written at level 1, visible at 1 and 3
		add_entry(sec_mem_pkg::MEM_WRITE, 32'h04, 32'h1111_aaaa, 2'd1, 1'b0, '0);
		add_entry(sec_mem_pkg::MEM_READ,  32'h04, '0, 2'd1, 1'b0, 32'h1111_aaaa);
		add_entry(sec_mem_pkg::MEM_READ,  32'h04, '0, 2'd3, 1'b0, 32'h1111_aaaa);
		// written at level 3, masked at level 0
		add_entry(sec_mem_pkg::MEM_WRITE, 32'h08, 32'hdead_beef, 2'd3, 1'b0, '0);
		add_entry(sec_mem_pkg::MEM_WRITE, 32'h0c, 32'hc3c3_3c3c, 2'd3, 1'b0, '0);
		add_entry(sec_mem_pkg::MEM_READ,  32'h08, '0, 2'd0, 1'b0, '0);
		add_entry(sec_mem_pkg::MEM_READ,  32'h08, '0, 2'd3, 1'b0, 32'hdead_beef);
		// rewrite at level 0 lowers the tag
		add_entry(sec_mem_pkg::MEM_WRITE, 32'h08, 32'h5a5a_0001, 2'd0, 1'b0, '0);
		add_entry(sec_mem_pkg::MEM_READ,  32'h08, '0, 2'd0, 1'b0, 32'h5a5a_0001);
		// back-to-back at level 2 with random back-pressure
		for (int w = 10; w < 14; w++) begin
			add_entry(sec_mem_pkg::MEM_WRITE, 32'(4 * w), 32'hb000_0000 | 32'(w), 2'd2,
				1'b1, '0);
		end
		for (int w = 10; w < 14; w++) begin
			add_entry(sec_mem_pkg::MEM_READ, 32'(4 * w), '0, 2'd2, 1'b1,
				32'hb000_0000 | 32'(w));
		end
		add_entry(sec_mem_pkg::MEM_READ,  32'h0c, '0, 2'd2, 1'b1, '0);
		add_entry(sec_mem_pkg::MEM_READ,  32'h08, '0, 2'd2, 1'b1, 32'h5a5a_0001);
		add_entry(sec_mem_pkg::MEM_READ,  32'h04, '0, 2'd2, 1'b1, 32'h1111_aaaa);
		add_entry(sec_mem_pkg::MEM_READ,  32'h3c, '0, 2'd2, 1'b1, '0);
		add_entry(sec_mem_pkg::MEM_WRITE, 32'h28, 32'hb000_00aa, 2'd2, 1'b1, '0);
		add_entry(sec_mem_pkg::MEM_READ,  32'h28, '0, 2'd2, 1'b1, 32'hb000_00aa);
	endtask

	// ====================
	// stimulus
	// ====================

	initial begin : drive
		logic fired;
		build_table();
		cycle_limit = stim.size() * 20;
		wait (arst_n);
		@(posedge clk);
		#2;
		for (int i = 0; i < stim.size(); i++) begin
			if (stim[i].level != proc_sec_level) begin
				wait_drained();
			end
			proc_sec_level   = stim[i].level;
			req_msg.msg_type = stim[i].kind;
			req_msg.opaque   = 8'(i);
			req_msg.addr     = stim[i].addr;
			req_msg.data     = stim[i].data;
			exp_data         = stim[i].exp_data;
			req_val          = 1'b1;
			set_resp_rdy(stim[i].bp);
			// hold the request until it transfers
			do begin
				@(negedge clk);
				fired = req_rdy;
				@(posedge clk);
				#2;
				set_resp_rdy(stim[i].bp);
			end while (!fired);
			req_val = 1'b0;
		end
		wait_drained();
		done = 1'b1;
		repeat (2) @(posedge clk);
		if (error_count == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	// ====================
	// timeout
	// ====================

	initial begin : watchdog
		wait (cycle_limit != 0);
		while (cycle_count < cycle_limit) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("error: run stopped by timeout after %0d cycles", cycle_count);
		$display("TESTS FAILED");
		$finish;
	end

endmodule
